//--- compile.f
+incdir+logic
logic/led_ctrl_pkg.sv
logic/cmd_decode.sv
logic/pixel_writer.sv
logic/panel_blanker.sv
logic/panel_outputs.sv
logic/led_ctrl_top.sv
dv/led_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with verilator and check the run output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module led_ctrl_tb \
    -f compile.f -o led_ctrl_sim || { echo "build failed"; exit 1; }
sim_out=$(./obj_dir/led_ctrl_sim)
echo "$sim_out"
echo "$sim_out" | grep -qx "Done: no errors" && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}

//--- dv/led_ctrl_tb.sv
`timescale 1ns/1ps
`include "led_ctrl_params.svh"

module led_ctrl_tb;

    localparam int sweep_cycles   = `RAM_WORDS;
    // settings and pixel tests together stay near this
    localparam int other_cycles   = 200;
    localparam int timeout_cycles = sweep_cycles + other_cycles + 1704;

    logic                          clk_in;
    logic                          reset;
    logic [7:0]                    data_rx;
    logic                          data_valid;
    logic [2:0]                    rgb_enable;
    logic [`BRIGHTNESS_LEVELS-1:0] brightness_enable;
    logic [`RAM_ADDR_BITS-1:0]     ram_address;
    logic [7:0]                    ram_data;
    logic                          ram_write_enable;
    logic                          busy;

    logic [7:0]                ram_model [0:`RAM_WORDS-1];
    logic [`RAM_ADDR_BITS-1:0] write_addr_q [$];
    logic [7:0]                write_data_q [$];
    int                        write_cycle_q [$];

    int                            cycle_count;
    int                            drive_cycle;
    int                            error_count;
    int                            test_count;
    int                            failed_tests;
    int                            test_errors_start;
    integer                        seed;
    logic [2:0]                    exp_rgb;
    logic [`BRIGHTNESS_LEVELS-1:0] exp_bright;

    led_ctrl_top u_led_ctrl_top (
        .clk_in            (clk_in),
        .reset             (reset),
        .data_rx           (data_rx),
        .data_valid        (data_valid),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .ram_address       (ram_address),
        .ram_data          (ram_data),
        .ram_write_enable  (ram_write_enable),
        .busy              (busy)
    );

    always #5 clk_in = ~clk_in;

    always @(posedge clk_in) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("run stopped after %0d cycles without finishing", cycle_count);
            $display("Done: errors found");
            $finish;
        end
    end

    // RAM model sampled mid cycle where the port is stable
    always @(negedge clk_in) begin
        if (ram_write_enable === 1'b1) begin
            ram_model[ram_address] = ram_data;
            write_addr_q.push_back(ram_address);
            write_data_q.push_back(ram_data);
            write_cycle_q.push_back(cycle_count);
        end
    end

    task automatic next_sample();
        @(negedge clk_in);
        #1;
    endtask

    task automatic send_byte(input logic [7:0] value);
        @(posedge clk_in);
        #1;
        data_rx     = value;
        data_valid  = 1'b1;
        drive_cycle = cycle_count;
        @(posedge clk_in);
        #1;
        data_valid = 1'b0;
    endtask

    task automatic expect_equal(input logic [31:0] actual, input logic [31:0] expected,
                                input string what);
        assert (actual === expected) else begin
            $display("** Error at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic wait_for_writes(input int target, input int limit);
        int waited;
        waited = 0;
        while (write_addr_q.size() < target && waited < limit) begin
            next_sample();
            waited++;
        end
        assert (write_addr_q.size() >= target) else begin
            $display("expected RAM writes did not arrive within %0d cycles", limit);
            error_count++;
        end
    endtask

    task automatic begin_test();
        test_errors_start = error_count;
        test_count++;
    endtask

    task automatic end_test(input string name);
        if (error_count == test_errors_start) begin
            $display("test %0d %s: passed", test_count, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: failed with %0d errors", test_count, name,
                     error_count - test_errors_start);
        end
    endtask

    // old value one edge after the byte is taken and the new value on the next
    task automatic apply_setting(input logic [7:0] value, input logic [2:0] new_rgb,
                                 input logic [`BRIGHTNESS_LEVELS-1:0] new_bright);
        int writes_before;
        writes_before = write_addr_q.size();
        send_byte(value);
        next_sample();
        expect_equal(rgb_enable, exp_rgb, "rgb_enable before update");
        expect_equal(brightness_enable, exp_bright, "brightness_enable before update");
        next_sample();
        expect_equal(rgb_enable, new_rgb, "rgb_enable");
        expect_equal(brightness_enable, new_bright, "brightness_enable");
        expect_equal(write_addr_q.size(), writes_before, "write count after setting");
        exp_rgb    = new_rgb;
        exp_bright = new_bright;
    endtask

    task automatic check_reset_state();
        begin_test();
        next_sample();
        expect_equal(rgb_enable, 3'b111, "rgb_enable after reset");
        expect_equal(brightness_enable, {`BRIGHTNESS_LEVELS{1'b1}}, "brightness after reset");
        expect_equal(busy, 1'b0, "busy after reset");
        expect_equal(ram_write_enable, 1'b0, "ram_write_enable after reset");
        repeat (4) next_sample();
        expect_equal(write_addr_q.size(), 0, "write count after reset");
        end_test("reset state");
    endtask

    // channel 0 is red, 1 green, 2 blue
    task automatic rgb_enable_test();
        begin_test();
        apply_setting("r", 3'b110, exp_bright);
        apply_setting("g", 3'b100, exp_bright);
        apply_setting("B", 3'b100, exp_bright);
        apply_setting("b", 3'b000, exp_bright);
        apply_setting("R", 3'b001, exp_bright);
        end_test("rgb enables");
    endtask

    // plane 1 is the top bit
    task automatic brightness_test();
        begin_test();
        apply_setting("0", exp_rgb, 6'b000000);
        apply_setting("2", exp_rgb, 6'b010000);
        apply_setting("9", exp_rgb, 6'b111111);
        apply_setting("1", exp_rgb, 6'b011111);
        apply_setting("T", exp_rgb, 6'b011111);
        apply_setting(8'h15, exp_rgb, 6'b010101);
        end_test("brightness planes");
    endtask

    task automatic write_pixel(input logic [7:0] row, input logic [7:0] col,
                               input logic [7:0] colour0, input logic [7:0] colour1);
        int                        first;
        int                        row_full;
        int                        col_full;
        int                        colour0_cycle;
        int                        colour1_cycle;
        logic [`ROW_BITS-1:0]      row_idx;
        logic [`COL_BITS-1:0]      col_idx;
        logic [`RAM_ADDR_BITS-1:0] addr0;
        logic [`RAM_ADDR_BITS-1:0] addr1;
        row_full = row % `PIXEL_HEIGHT;
        col_full = col % `PIXEL_WIDTH;
        row_idx  = row_full[`ROW_BITS-1:0];
        col_idx  = col_full[`COL_BITS-1:0];
        // column and byte select count down in memory
        addr0 = {row_idx, ~col_idx, 1'b1};
        addr1 = {row_idx, ~col_idx, 1'b0};
        first = write_addr_q.size();
        send_byte("P");
        send_byte(row);
        send_byte(col);
        send_byte(colour0);
        colour0_cycle = drive_cycle;
        send_byte(colour1);
        colour1_cycle = drive_cycle;
        wait_for_writes(first + 2, 10);
        repeat (3) next_sample();
        expect_equal(write_addr_q.size(), first + 2, "pixel write count");
        if (write_addr_q.size() >= first + 2) begin
            expect_equal(write_addr_q[first], addr0, "first colour address");
            expect_equal(write_data_q[first], colour0, "first colour data");
            expect_equal(write_cycle_q[first], colour0_cycle + 3, "first colour write cycle");
            expect_equal(write_addr_q[first + 1], addr1, "second colour address");
            expect_equal(write_data_q[first + 1], colour1, "second colour data");
            expect_equal(write_cycle_q[first + 1], colour1_cycle + 3, "second write cycle");
        end
        expect_equal(ram_model[addr0], colour0, "RAM byte 0 of pixel");
        expect_equal(ram_model[addr1], colour1, "RAM byte 1 of pixel");
    endtask

    task automatic pixel_write_test();
        logic [7:0] row;
        logic [7:0] col;
        logic [7:0] colour0;
        logic [7:0] colour1;
        begin_test();
        repeat (8) begin
            row     = 8'($random(seed));
            col     = 8'($random(seed));
            colour0 = 8'($random(seed));
            colour1 = 8'($random(seed));
            write_pixel(row, col, colour0, colour1);
        end
        end_test("pixel writes");
    endtask

    task automatic blank_panel_test();
        int first;
        int waited;
        int fall_cycle;
        int last_cycle;
        int i;
        begin_test();
        first = write_addr_q.size();
        send_byte("Z");
        expect_equal(busy, 1'b1, "busy after Z");
        // a whole pixel command during the sweep is dropped
        send_byte("P");
        send_byte(8'h03);
        send_byte(8'h05);
        send_byte(8'haa);
        send_byte(8'h55);
        waited = 0;
        while (busy && waited < sweep_cycles + 20) begin
            next_sample();
            waited++;
        end
        fall_cycle = cycle_count;
        assert (!busy) else begin
            $display("busy stayed high after the blank sweep should have ended");
            error_count++;
        end
        repeat (4) next_sample();
        expect_equal(write_addr_q.size(), first + sweep_cycles, "blank write count");
        if (write_addr_q.size() >= first + sweep_cycles) begin
            for (i = 0; i < sweep_cycles; i++) begin
                expect_equal(write_addr_q[first + i], i, "sweep address");
                expect_equal(write_data_q[first + i], 8'h00, "sweep data");
                expect_equal(write_cycle_q[first + i], write_cycle_q[first] + i, "sweep cycle");
            end
            last_cycle = write_cycle_q[first + sweep_cycles - 1];
            expect_equal(fall_cycle, last_cycle + 1, "cycle busy falls");
        end
        for (i = 0; i < `RAM_WORDS; i++) begin
            expect_equal(ram_model[i], 8'h00, "RAM byte after blank");
        end
        end_test("panel blank");
    endtask

    task automatic unknown_byte_test();
        begin_test();
        apply_setting("r", exp_rgb & 3'b110, exp_bright);
        apply_setting("x", exp_rgb, exp_bright);
        expect_equal(busy, 1'b0, "busy after unknown byte");
        apply_setting("R", exp_rgb | 3'b001, exp_bright);
        end_test("unknown byte");
    endtask

    initial begin
        int addr;
        clk_in       = 1'b0;
        reset        = 1'b1;
        data_rx      = 8'h00;
        data_valid   = 1'b0;
        cycle_count  = 0;
        drive_cycle  = 0;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        seed         = 32'h2959_9f43;
        exp_rgb      = 3'b111;
        exp_bright   = {`BRIGHTNESS_LEVELS{1'b1}};
        // fill from the whole address so a missed blank write shows up
        for (addr = 0; addr < `RAM_WORDS; addr++) begin
            ram_model[addr] = {addr[6:0] ^ addr[11:5], 1'b1};
        end
        repeat (3) @(posedge clk_in);
        #1;
        reset = 1'b0;
        check_reset_state();
        rgb_enable_test();
        brightness_test();
        pixel_write_test();
        blank_panel_test();
        unknown_byte_test();
        $display("summary: %0d tests, %0d failed, %0d errors", test_count, failed_tests,
                 error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- logic/led_ctrl_top.sv
`timescale 1ns/1ps
`include "led_ctrl_params.svh"

module led_ctrl_top (
    input  logic                          clk_in,
    input  logic                          reset,
    input  logic [7:0]                    data_rx,
    input  logic                          data_valid,
    output logic [2:0]                    rgb_enable,
    output logic [`BRIGHTNESS_LEVELS-1:0] brightness_enable,
    output logic [`RAM_ADDR_BITS-1:0]     ram_address,
    output logic [7:0]                    ram_data,
    output logic                          ram_write_enable,
    output logic                          busy
);
    import led_ctrl_pkg::*;

    setting_op_t               setting_op;
    logic [7:0]                setting_arg;
    logic                      pixel_start;
    logic [7:0]                arg_byte;
    logic                      arg_valid;
    logic                      blank_start;
    logic                      pixel_done;
    logic                      blank_done;
    logic                      pixel_wr_strobe;
    logic [`RAM_ADDR_BITS-1:0] pixel_wr_address;
    logic [7:0]                pixel_wr_data;
    logic                      blank_wr_strobe;
    logic [`RAM_ADDR_BITS-1:0] blank_wr_address;

    cmd_decode u_decode (
        .clk_in      (clk_in),
        .reset       (reset),
        .data_rx     (data_rx),
        .data_valid  (data_valid),
        .pixel_done  (pixel_done),
        .blank_done  (blank_done),
        .setting_op  (setting_op),
        .setting_arg (setting_arg),
        .pixel_start (pixel_start),
        .arg_byte    (arg_byte),
        .arg_valid   (arg_valid),
        .blank_start (blank_start),
        .busy        (busy)
    );

    pixel_writer u_pixel_writer (
        .clk_in      (clk_in),
        .reset       (reset),
        .pixel_start (pixel_start),
        .arg_byte    (arg_byte),
        .arg_valid   (arg_valid),
        .wr_strobe   (pixel_wr_strobe),
        .wr_address  (pixel_wr_address),
        .wr_data     (pixel_wr_data),
        .pixel_done  (pixel_done)
    );

    panel_blanker u_panel_blanker (
        .clk_in      (clk_in),
        .reset       (reset),
        .blank_start (blank_start),
        .wr_strobe   (blank_wr_strobe),
        .wr_address  (blank_wr_address),
        .blank_done  (blank_done)
    );

    panel_outputs u_panel_outputs (
        .clk_in            (clk_in),
        .reset             (reset),
        .setting_op        (setting_op),
        .setting_arg       (setting_arg),
        .pixel_wr_strobe   (pixel_wr_strobe),
        .pixel_wr_address  (pixel_wr_address),
        .pixel_wr_data     (pixel_wr_data),
        .blank_wr_strobe   (blank_wr_strobe),
        .blank_wr_address  (blank_wr_address),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .ram_address       (ram_address),
        .ram_data          (ram_data),
        .ram_write_enable  (ram_write_enable)
    );

endmodule

//--- logic/panel_outputs.sv
`timescale 1ns/1ps
`include "led_ctrl_params.svh"

module panel_outputs (
    input  logic                          clk_in,
    input  logic                          reset,
    input  led_ctrl_pkg::setting_op_t     setting_op,
    input  logic [7:0]                    setting_arg,
    input  logic                          pixel_wr_strobe,
    input  logic [`RAM_ADDR_BITS-1:0]     pixel_wr_address,
    input  logic [7:0]                    pixel_wr_data,
    input  logic                          blank_wr_strobe,
    input  logic [`RAM_ADDR_BITS-1:0]     blank_wr_address,
    output logic [2:0]                    rgb_enable,
    output logic [`BRIGHTNESS_LEVELS-1:0] brightness_enable,
    output logic [`RAM_ADDR_BITS-1:0]     ram_address,
    output logic [7:0]                    ram_data,
    output logic                          ram_write_enable
);
    import led_ctrl_pkg::*;

    localparam int plane_bits = $clog2(`BRIGHTNESS_LEVELS);

    logic [1:0]            channel;
    logic [plane_bits-1:0] plane;

    assign channel = setting_arg[1:0];
    assign plane   = setting_arg[plane_bits-1:0];

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            rgb_enable        <= 3'b111;
            brightness_enable <= {`BRIGHTNESS_LEVELS{1'b1}};
            ram_write_enable  <= 1'b0;
        end else begin
            // engines never overlap
            ram_write_enable <= pixel_wr_strobe | blank_wr_strobe;
            case (setting_op)
                op_rgb_set:          rgb_enable[channel] <= 1'b1;
                op_rgb_clear:        rgb_enable[channel] <= 1'b0;
                op_bright_toggle:    brightness_enable[plane] <= ~brightness_enable[plane];
                op_bright_clear_all: brightness_enable <= '0;
                op_bright_set_all:   brightness_enable <= {`BRIGHTNESS_LEVELS{1'b1}};
                op_bright_load:      brightness_enable <= setting_arg[`BRIGHTNESS_LEVELS-1:0];
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (pixel_wr_strobe) begin
            ram_address <= pixel_wr_address;
            ram_data    <= pixel_wr_data;
        end else if (blank_wr_strobe) begin
            ram_address <= blank_wr_address;
            // blanking writes black
            ram_data    <= 8'h00;
        end
    end

endmodule

//--- logic/panel_blanker.sv
`timescale 1ns/1ps
`include "led_ctrl_params.svh"

module panel_blanker (
    input  logic                      clk_in,
    input  logic                      reset,
    input  logic                      blank_start,
    output logic                      wr_strobe,
    output logic [`RAM_ADDR_BITS-1:0] wr_address,
    output logic                      blank_done
);
    localparam logic [`RAM_ADDR_BITS-1:0] last_address = `RAM_ADDR_BITS'(`RAM_WORDS - 1);

    logic [`RAM_ADDR_BITS-1:0] next_address;

    assign next_address = wr_address + 1'b1;

    // wr_address doubles as the sweep counter
    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            wr_strobe  <= 1'b0;
            wr_address <= '0;
            blank_done <= 1'b0;
        end else if (blank_start) begin
            wr_strobe  <= 1'b1;
            wr_address <= '0;
            blank_done <= 1'b0;
        end else if (wr_strobe) begin
            if (wr_address == last_address) begin
                wr_strobe  <= 1'b0;
                blank_done <= 1'b0;
            end else begin
                wr_address <= next_address;
                // flag rides with the final write
                blank_done <= (next_address == last_address);
            end
        end
    end

endmodule

//--- logic/pixel_writer.sv
`timescale 1ns/1ps
`include "led_ctrl_params.svh"

module pixel_writer (
    input  logic                      clk_in,
    input  logic                      reset,
    input  logic                      pixel_start,
    input  logic [7:0]                arg_byte,
    input  logic                      arg_valid,
    output logic                      wr_strobe,
    output logic [`RAM_ADDR_BITS-1:0] wr_address,
    output logic [7:0]                wr_data,
    output logic                      pixel_done
);
    // row, column, then the colour bytes
    localparam logic [1:0] last_arg = 2'(1 + `BYTES_PER_PIXEL);

    logic [1:0]                arg_count;
    logic [`ROW_BITS-1:0]      row;
    logic [`COL_BITS-1:0]      col;
    logic [7:0]                row_mod;
    logic [7:0]                col_mod;
    logic [`BYTE_SEL_BITS-1:0] byte_sel;
    logic                      is_colour;

    assign row_mod   = arg_byte % 8'(`PIXEL_HEIGHT);
    assign col_mod   = arg_byte % 8'(`PIXEL_WIDTH);
    assign is_colour = arg_valid && (arg_count >= 2'd2);
    // first colour byte is index 0
    assign byte_sel  = arg_count[`BYTE_SEL_BITS-1:0];

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            arg_count  <= 2'd0;
            wr_strobe  <= 1'b0;
            pixel_done <= 1'b0;
        end else begin
            wr_strobe  <= is_colour;
            pixel_done <= arg_valid && (arg_count == last_arg);
            if (pixel_start) begin
                arg_count <= 2'd0;
            end else if (arg_valid) begin
                arg_count <= arg_count + 2'd1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (arg_valid) begin
            case (arg_count)
                2'd0: row <= row_mod[`ROW_BITS-1:0];
                2'd1: col <= col_mod[`COL_BITS-1:0];
                default: begin
                    wr_address <= {row, ~col, ~byte_sel};
                    wr_data    <= arg_byte;
                end
            endcase
        end
    end

endmodule

//--- logic/cmd_decode.sv
`timescale 1ns/1ps
`include "led_ctrl_params.svh"

module cmd_decode (
    input  logic                     clk_in,
    input  logic                     reset,
    input  logic [7:0]               data_rx,
    input  logic                     data_valid,
    input  logic                     pixel_done,
    input  logic                     blank_done,
    output led_ctrl_pkg::setting_op_t setting_op,
    output logic [7:0]               setting_arg,
    output logic                     pixel_start,
    output logic [7:0]               arg_byte,
    output logic                     arg_valid,
    output logic                     blank_start,
    output logic                     busy
);
    import led_ctrl_pkg::*;

    decode_state_t state;
    decode_state_t state_next;
    setting_op_t   op_next;
    logic [7:0]    arg_next;
    logic          pixel_start_next;
    logic          arg_valid_next;
    logic          blank_start_next;
    logic          blank_done_q;

    always_comb begin
        state_next       = state;
        op_next          = op_none;
        arg_next         = setting_arg;
        pixel_start_next = 1'b0;
        arg_valid_next   = 1'b0;
        blank_start_next = 1'b0;
        case (state)
            st_idle: begin
                if (data_valid) begin
                    case (data_rx)
                        "R": begin
                            op_next  = op_rgb_set;
                            arg_next = 8'd0;
                        end
                        "r": begin
                            op_next  = op_rgb_clear;
                            arg_next = 8'd0;
                        end
                        "G": begin
                            op_next  = op_rgb_set;
                            arg_next = 8'd1;
                        end
                        "g": begin
                            op_next  = op_rgb_clear;
                            arg_next = 8'd1;
                        end
                        "B": begin
                            op_next  = op_rgb_set;
                            arg_next = 8'd2;
                        end
                        "b": begin
                            op_next  = op_rgb_clear;
                            arg_next = 8'd2;
                        end
                        // "1" is the top plane
                        "1", "2", "3", "4", "5", "6": begin
                            op_next  = op_bright_toggle;
                            arg_next = 8'(`BRIGHTNESS_LEVELS) + 8'h30 - data_rx;
                        end
                        "0": op_next = op_bright_clear_all;
                        "9": op_next = op_bright_set_all;
                        "T": state_next = st_brightness_arg;
                        "P": begin
                            state_next       = st_pixel;
                            pixel_start_next = 1'b1;
                        end
                        "Z": begin
                            state_next       = st_blank;
                            blank_start_next = 1'b1;
                        end
                        default: begin
                        end
                    endcase
                end
            end
            st_brightness_arg: begin
                if (data_valid) begin
                    op_next    = op_bright_load;
                    arg_next   = data_rx;
                    state_next = st_idle;
                end
            end
            st_pixel: begin
                if (pixel_done) begin
                    state_next = st_idle;
                end else if (data_valid) begin
                    arg_valid_next = 1'b1;
                end
            end
            st_blank: begin
                // hold one extra cycle so the last write leaves the port first
                if (blank_done_q) begin
                    state_next = st_idle;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            state        <= st_idle;
            setting_op   <= op_none;
            pixel_start  <= 1'b0;
            arg_valid    <= 1'b0;
            blank_start  <= 1'b0;
            blank_done_q <= 1'b0;
        end else begin
            state        <= state_next;
            setting_op   <= op_next;
            pixel_start  <= pixel_start_next;
            arg_valid    <= arg_valid_next;
            blank_start  <= blank_start_next;
            blank_done_q <= blank_done;
        end
    end

    always_ff @(posedge clk_in) begin
        setting_arg <= arg_next;
        if (arg_valid_next) begin
            arg_byte <= data_rx;
        end
    end

    assign busy = (state == st_blank);

endmodule

//--- logic/led_ctrl_pkg.sv
package led_ctrl_pkg;

    // setting operations passed from decode to the result stage
    typedef enum logic [2:0] {
        op_none,
        op_rgb_set,
        op_rgb_clear,
        op_bright_toggle,
        op_bright_clear_all,
        op_bright_set_all,
        op_bright_load
    } setting_op_t;

    // command decoder states
    typedef enum logic [1:0] {
        st_idle,
        st_brightness_arg,
        st_pixel,
        st_blank
    } decode_state_t;

endpackage

//--- logic/led_ctrl_params.svh
`ifndef LED_CTRL_PARAMS_SVH
`define LED_CTRL_PARAMS_SVH

// panel geometry
`define PIXEL_HEIGHT 32
`define PIXEL_WIDTH 64
`define BYTES_PER_PIXEL 2

// number of brightness bit planes
`define BRIGHTNESS_LEVELS 6

// frame buffer address is row then column then byte select
`define ROW_BITS 5
`define COL_BITS 6
`define BYTE_SEL_BITS 1
`define RAM_ADDR_BITS 12
`define RAM_WORDS 4096

`endif
